//--- flist.f
+incdir+tests
src/rv_isa_pkg.sv
src/soc_map_pkg.sv
src/fetch_stage.sv
src/exec_unit.sv
src/trap_ctrl.sv
src/pc_sequencer.sv
src/riscv_core_top.sv
tests/tb_riscv_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_riscv_core
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "No errors" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Instruction level model of the program in the ROM
// Records the expected bus traffic and the trap and return pc values
function automatic void ref_run(input logic [xlen-1:0] take_pc);
    logic [xlen-1:0] x [reg_count];
    logic [xlen-1:0] csr [logic [11:0]];
    logic [xlen-1:0] cur, nxt, a, old, ms;
    logic [ilen-1:0] w;
    logic            taken, returned;
    int              steps;
    foreach (x[i]) x[i] = '0;
    csr[csr_mstatus] = '0;
    csr[csr_mie]     = '0;
    csr[csr_mtvec]   = '0;
    csr[csr_mepc]    = '0;
    csr[csr_mcause]  = '0;
    cur      = ram_base;
    taken    = 1'b0;
    returned = 1'b0;
    steps    = 0;
    // Stops once the return path runs back into the handler
    while (steps < 1000 && !(returned && cur == exp_vector)) begin
        steps++;
        w   = rom_word(cur);
        nxt = cur + 64'd4;
        ms  = csr[csr_mstatus];
        if (!taken && cur == take_pc && ms[mstatus_mie_bit] && csr[csr_mie][mie_meie_bit]) begin
            taken = 1'b1;                        // Instruction at take_pc is not executed
            csr[csr_mepc]   = cur;
            csr[csr_mcause] = mcause_ext_irq;
            ms[mstatus_mpie_bit] = ms[mstatus_mie_bit];
            ms[mstatus_mie_bit]  = 1'b0;
            exp_vector = {csr[csr_mtvec][xlen-1:2], 2'b00};
            nxt        = exp_vector;
        end else if (w == mret_word) begin
            ms[mstatus_mie_bit]  = ms[mstatus_mpie_bit];
            ms[mstatus_mpie_bit] = 1'b1;
            exp_return = csr[csr_mepc];
            nxt        = exp_return;
            returned   = 1'b1;
        end else begin
            case (w[6:0])
                op_lui:    x[w[11:7]] = {{32{w[31]}}, w[31:12], 12'h000};
                op_op_imm: x[w[11:7]] = x[w[19:15]] + {{52{w[31]}}, w[31:20]};
                op_load: begin
                    a = x[w[19:15]] + {{52{w[31]}}, w[31:20]};
                    exp_load_addr.push_back(a);
                    x[w[11:7]] = mem_read(a);
                end
                op_store: begin
                    a = x[w[19:15]] + {{52{w[31]}}, w[31:25], w[11:7]};
                    exp_st_addr.push_back(a);
                    exp_st_data.push_back(x[w[24:20]]);
                end
                op_system: begin
                    old = csr[w[31:20]];         // CSRRW swaps old value into rd
                    csr[w[31:20]] = x[w[19:15]];
                    x[w[11:7]] = old;
                    ms = csr[csr_mstatus];
                end
                default: ;
            endcase
            x[0] = '0;
        end
        csr[csr_mstatus] = ms;
        cur = nxt;
    end
endfunction

`endif

//--- tests/tb_riscv_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_riscv_core
    import rv_isa_pkg::*;
    import soc_map_pkg::*;
();

    localparam int rom_words      = 192;
    localparam int timeout_cycles = 300;
    localparam logic [xlen-1:0] irq_pc     = ram_base + 64'd120;  // ROM slot 30
    localparam logic [xlen-1:0] flush_addr = art_base + 64'd256;  // SD behind the MRET
    localparam int wait_pc_eq = 0;
    localparam int wait_ack   = 1;
    localparam int wait_pc_lt = 2;
    localparam int wait_drain = 3;

    logic            clk = 1'b0;
    logic            reset;
    logic            irq;
    logic [xlen-1:0] bus_read_data;
    logic [ilen-1:0] instruction;
    logic [xlen-1:0] pc;
    bus_req_t        bus;
    logic            irq_ack;
    logic            heartbeat;

    logic [ilen-1:0] rom [rom_words];
    logic [xlen-1:0] mem [logic [xlen-1:0]];  // Sparse data memory
    logic [xlen-1:0] exp_st_addr[$];
    logic [xlen-1:0] exp_st_data[$];
    logic [xlen-1:0] exp_load_addr[$];
    logic [xlen-1:0] exp_vector;
    logic [xlen-1:0] exp_return;
    logic [xlen-1:0] ld_pc;
    logic            hb_exp;  // Heartbeat low after reset, then toggles every cycle
    logic [31:0]     seed;
    int errors, checks, ack_count, store_count, ld_phase;
    bit timed_out;

    always #2 clk = ~clk;  // 4 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [ilen-1:0] rom_word(input logic [xlen-1:0] a);
        if (a >= ram_base && a < ram_base + 64'(4 * rom_words)) begin
            return rom[int'((a - ram_base) >> 2)];
        end
        return nop_word;  // Outside the ROM
    endfunction

    function automatic logic [xlen-1:0] mem_read(input logic [xlen-1:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ {a[31:0], a[63:32]} ^ 64'hc3a5_5a3c_0f0f_f0f0;  // Fill from whole address
    endfunction

    // Instruction encoders
    function automatic logic [ilen-1:0] enc_i(input logic [11:0] imm, input int rs1,
                                              input logic [2:0] f3, input int rd,
                                              input logic [6:0] op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [ilen-1:0] enc_lui(input logic [19:0] imm, input int rd);
        return {imm, 5'(rd), op_lui};
    endfunction

    function automatic logic [ilen-1:0] enc_sd(input logic [11:0] imm, input int rs2,
                                               input int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), funct3_sd, imm[4:0], op_store};
    endfunction

    function automatic string store_name(input int n);
        case (n)
            0:       return "lui_addi_sd";
            1:       return "addi_neg_sd";
            2:       return "ld_sd";
            3:       return "irq_mcause_sd";
            4:       return "mret_resume_sd";
            default: return "extra_sd";
        endcase
    endfunction

    `include "tb_ref_model.svh"

    task automatic check_bus_req(input string name, input bus_req_t exp, input bus_req_t act);
        checks++;
        if (act.write_enable !== exp.write_enable || act.read_enable !== exp.read_enable
            || ((exp.write_enable || exp.read_enable) && act.address !== exp.address)
            || (exp.write_enable && act.write_data !== exp.write_data)) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_pc(input string name, input logic [xlen-1:0] exp,
                            input logic [xlen-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_ack(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_heartbeat(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
        end
    endtask

    // Each call polls its own condition with its own cycle limit
    task automatic wait_for(input int kind, input logic [xlen-1:0] v, input string what);
        int n;
        bit hit;
        n   = 0;
        hit = 1'b0;
        while (!timed_out && !hit) begin
            @(negedge clk);
            case (kind)
                wait_pc_eq: hit = (pc == v);
                wait_ack:   hit = irq_ack;
                wait_pc_lt: hit = (pc < v);
                default:    hit = (exp_st_addr.size() == 0);
            endcase
            n++;
            if (!hit && n >= timeout_cycles) begin
                timed_out = 1'b1;
                errors++;
                $display("Timed out waiting for %s", what);
            end
        end
    endtask

    task automatic load_program();
        foreach (rom[i]) rom[i] = nop_word;
        rom[0]   = enc_lui(key_base[31:12], 1);                  // x1 key device
        rom[1]   = enc_lui(art_base[31:12], 2);                  // x2 output device
        rom[2]   = enc_lui(20'h12345, 3);
        rom[3]   = enc_i(12'h678, 3, funct3_addi, 3, op_op_imm);
        rom[4]   = enc_sd(12'd0, 3, 2);
        rom[5]   = enc_i(12'hffb, 0, funct3_addi, 4, op_op_imm); // -5
        rom[6]   = enc_sd(12'd8, 4, 2);
        rom[8]   = enc_i(12'd16, 1, funct3_ld, 5, op_load);
        rom[9]   = enc_sd(12'd16, 5, 2);                         // Store the loaded value
        rom[10]  = enc_lui(20'h1, 6);
        rom[11]  = enc_i(12'h200, 6, funct3_addi, 6, op_op_imm); // Handler at 0x1200
        rom[12]  = enc_i(csr_mtvec, 6, funct3_csrrw, 0, op_system);
        rom[13]  = enc_lui(20'h1, 7);
        rom[14]  = enc_i(12'h800, 7, funct3_addi, 7, op_op_imm); // MEIE mask 0x800
        rom[15]  = enc_i(csr_mie, 7, funct3_csrrw, 0, op_system);
        rom[16]  = enc_i(12'd8, 0, funct3_addi, 8, op_op_imm);
        rom[17]  = enc_i(csr_mstatus, 8, funct3_csrrw, 9, op_system);
        rom[30]  = enc_sd(12'd24, 3, 2);                         // Suppressed, then replayed
        rom[128] = enc_i(csr_mcause, 0, funct3_csrrw, 10, op_system);
        rom[129] = enc_sd(12'd40, 10, 2);
        rom[130] = mret_word;
        rom[131] = enc_sd(12'd256, 3, 2);                        // Must be flushed
    endtask

    always_comb instruction = rom_word(pc);

    // Data memory, read data one cycle after the strobe
    always @(posedge clk) begin
        if (bus.read_enable) bus_read_data <= mem_read(bus.address);
        if (bus.write_enable) mem[bus.address] = bus.write_data;
    end

    // Compare process for bus traffic, load stall and acks
    always @(negedge clk) begin : compare
        bus_req_t exp;
        if (reset) begin
            check_heartbeat("heartbeat", hb_exp, heartbeat);
            hb_exp = ~hb_exp;
            if (irq_ack) ack_count++;
            if (bus.write_enable) begin
                if (bus.address == flush_addr) begin
                    errors++;
                    $display("Flushed store reached the bus at %h", bus.address);
                end else if (exp_st_addr.size() == 0) begin
                    errors++;
                    $display("Unexpected write at %h", bus.address);
                end else begin
                    exp = '0;
                    exp.address      = exp_st_addr.pop_front();
                    exp.write_data   = exp_st_data.pop_front();
                    exp.write_enable = 1'b1;
                    check_bus_req(store_name(store_count), exp, bus);
                    store_count++;
                end
            end
            if (ld_phase == 2) begin
                check_pc("ld_resume", ld_pc + 64'd4, pc);
                ld_phase = 0;
            end else if (ld_phase == 1) begin
                if (bus.read_enable) begin
                    errors++;
                    $display("read_enable stayed high for more than one cycle");
                end
                check_pc("ld_stall", ld_pc, pc);  // pc held for the data cycle
                ld_phase = 2;
            end else if (bus.read_enable) begin
                if (exp_load_addr.size() == 0) begin
                    errors++;
                    $display("Unexpected read at %h", bus.address);
                end else begin
                    exp = '0;
                    exp.address     = exp_load_addr.pop_front();
                    exp.read_enable = 1'b1;
                    check_bus_req("ld_read", exp, bus);
                end
                ld_pc    = pc;
                ld_phase = 1;
            end
        end
    end

    riscv_core_top riscv_core_top_i (
        .clk           (clk),
        .reset         (reset),
        .instruction   (instruction),
        .irq           (irq),
        .bus_read_data (bus_read_data),
        .pc            (pc),
        .bus           (bus),
        .irq_ack       (irq_ack),
        .heartbeat     (heartbeat)
    );

    initial begin
        reset         = 1'b0;
        irq           = 1'b0;
        bus_read_data = '0;
        errors        = 0;
        checks        = 0;
        ack_count     = 0;
        store_count   = 0;
        ld_phase      = 0;
        hb_exp        = 1'b0;
        timed_out     = 1'b0;
        exp_vector    = '0;
        exp_return    = '0;
        load_program();
        seed = 32'he03e;
        for (int i = 0; i < 8; i++) begin  // Key device words from the LCG
            seed = lcg_next(seed);
            mem[key_base + 64'(8 * i)] = {seed, lcg_next(seed)};
            seed = lcg_next(seed);
        end
        ref_run(irq_pc);
        repeat (8) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        check_pc("reset_pc", ram_base, pc);
        check_bus_req("reset_bus", '0, bus);
        check_ack("reset_ack", 1'b0, irq_ack);
        wait_for(wait_pc_eq, irq_pc, "pc at the interrupt slot");
        @(posedge clk);
        irq <= 1'b1;                               // Held through the handler
        wait_for(wait_ack, '0, "irq_ack");
        check_pc("irq_vector", exp_vector, pc);
        wait_for(wait_pc_lt, exp_vector, "return from the handler");
        check_pc("mret_return", exp_return, pc);
        if (ack_count != 1) begin
            errors++;
            $display("irq_ack pulsed %0d times inside the handler", ack_count);
        end
        @(posedge clk);
        irq <= 1'b0;
        wait_for(wait_drain, '0, "remaining stores");
        if (ack_count != 1) begin
            errors++;
            $display("irq_ack pulsed %0d times in total", ack_count);
        end
        $display("Checks %0d, stores %0d, errors %0d", checks, store_count, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/riscv_core_top.sv
`timescale 1ns/10ps
`default_nettype none

module riscv_core_top
    import rv_isa_pkg::*;
    import soc_map_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  wire [ilen-1:0]  instruction,   // Combinational answer for pc
    input  wire             irq,
    input  wire [xlen-1:0]  bus_read_data, // Valid the cycle after read_enable
    output logic [xlen-1:0] pc,
    output bus_req_t        bus,
    output logic            irq_ack,
    output logic            heartbeat
);

    logic [ilen-1:0] ir;
    logic            bubble;
    exec_ctl_t       exec_ctl;
    trap_ctl_t       trap_ctl;

    fetch_stage fetch_stage_i (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .bubble      (bubble),
        .ir          (ir),
        .heartbeat   (heartbeat)
    );

    exec_unit exec_unit_i (
        .clk           (clk),
        .reset         (reset),
        .ir            (ir),
        .bubble        (bubble),
        .trap_ctl      (trap_ctl),
        .bus_read_data (bus_read_data),
        .exec_ctl      (exec_ctl),
        .bus           (bus)
    );

    trap_ctrl trap_ctrl_i (
        .clk      (clk),
        .reset    (reset),
        .pc       (pc),
        .bubble   (bubble),
        .irq      (irq),
        .exec_ctl (exec_ctl),
        .trap_ctl (trap_ctl),
        .irq_ack  (irq_ack)
    );

    pc_sequencer pc_sequencer_i (
        .clk      (clk),
        .reset    (reset),
        .exec_ctl (exec_ctl),
        .trap_ctl (trap_ctl),
        .pc       (pc),
        .bubble   (bubble)
    );

endmodule

`default_nettype wire

//--- src/pc_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module pc_sequencer
    import rv_isa_pkg::*;
    import soc_map_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  wire exec_ctl_t  exec_ctl,
    input  wire trap_ctl_t  trap_ctl,
    output logic [xlen-1:0] pc,
    output logic            bubble   // Flush flag for the word fetched in a redirect cycle
);

    logic            redirect;
    logic [xlen-1:0] pc_next;

    // Take beats mret, trap_ctrl already chose mtvec over mepc for the target
    assign redirect = trap_ctl.take | exec_ctl.mret;

    always_comb begin
        if (redirect) begin
            pc_next = trap_ctl.target;
        end else if (exec_ctl.stall) begin
            pc_next = pc;               // Load in progress
        end else begin
            pc_next = pc + xlen'(4);
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc     <= ram_base;
            bubble <= 1'b0;
        end else begin
            pc     <= pc_next;          // Redirect lands on the next edge
            bubble <= redirect;         // High for exactly one cycle
        end
    end

endmodule

`default_nettype wire

//--- src/trap_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module trap_ctrl
    import rv_isa_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  wire [xlen-1:0]  pc,       // Fetch pc, one word ahead of execute
    input  wire             bubble,
    input  wire             irq,      // Level sensitive external interrupt
    input  wire exec_ctl_t  exec_ctl,
    output trap_ctl_t       trap_ctl,
    output logic            irq_ack
);

    logic [xlen-1:0] mstatus;
    logic [xlen-1:0] mie;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;
    logic            pending; // Handler running, cleared by mret
    logic            take;
    logic [xlen-1:0] rdata;

    // No take while a bubble or a load holds execute
    assign take = irq & mstatus[mstatus_mie_bit] & mie[mie_meie_bit] & ~pending
                  & ~bubble & ~exec_ctl.stall;

    always_comb begin
        case (exec_ctl.csr_addr)
            csr_mstatus: rdata = mstatus;
            csr_mie:     rdata = mie;
            csr_mtvec:   rdata = mtvec;
            csr_mepc:    rdata = mepc;
            csr_mcause:  rdata = mcause;
            default:     rdata = '0; // Unimplemented CSRs read as zero
        endcase
    end

    always_comb begin
        trap_ctl.take      = take;
        trap_ctl.target    = take ? {mtvec[xlen-1:2], 2'b00} : mepc; // Direct mode only
        trap_ctl.csr_rdata = rdata;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus <= '0;
            mie     <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
            pending <= 1'b0;
            irq_ack <= 1'b0;
        end else begin
            irq_ack <= take; // Single pulse, pending blocks a repeat
            if (take) begin
                mepc    <= pc - xlen'(4); // pc of the suppressed instruction
                mcause  <= mcause_ext_irq;
                mstatus[mstatus_mpie_bit] <= mstatus[mstatus_mie_bit];
                mstatus[mstatus_mie_bit]  <= 1'b0;
                pending <= 1'b1;
            end else if (exec_ctl.mret) begin
                mstatus[mstatus_mie_bit]  <= mstatus[mstatus_mpie_bit];
                mstatus[mstatus_mpie_bit] <= 1'b1;
                pending <= 1'b0;
            end else if (exec_ctl.csr_we) begin
                case (exec_ctl.csr_addr)
                    csr_mstatus: mstatus <= exec_ctl.csr_wdata;
                    csr_mie:     mie     <= exec_ctl.csr_wdata;
                    csr_mtvec:   mtvec   <= exec_ctl.csr_wdata;
                    csr_mepc:    mepc    <= exec_ctl.csr_wdata;
                    csr_mcause:  mcause  <= exec_ctl.csr_wdata;
                    default:     ;        // Writes elsewhere are dropped
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- src/exec_unit.sv
`timescale 1ns/10ps
`default_nettype none

module exec_unit
    import rv_isa_pkg::*;
    import soc_map_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  wire [ilen-1:0]  ir,
    input  wire             bubble,
    input  wire trap_ctl_t  trap_ctl,
    input  wire [xlen-1:0]  bus_read_data,
    output exec_ctl_t       exec_ctl,
    output bus_req_t        bus
);

    logic [xlen-1:0] regs [reg_count]; // x0 never written, stays zero

    logic [opcode_w-1:0]  opcode;
    logic [funct3_w-1:0]  funct3;
    logic [reg_idx_w-1:0] rd;
    logic [reg_idx_w-1:0] rs1;
    logic [reg_idx_w-1:0] rs2;
    logic [xlen-1:0]      imm_i;
    logic [xlen-1:0]      imm_s;
    logic [xlen-1:0]      imm_u;
    logic [xlen-1:0]      rs1_val;
    logic [xlen-1:0]      rs2_val;
    logic [xlen-1:0]      load_ea; // Effective address of an LD in execute

    logic load_step;               // Second load cycle, bus_read_data is valid
    logic load_wait;               // Read held back one cycle behind a store strobe
    logic [reg_idx_w-1:0] load_rd;
    logic [xlen-1:0]      load_addr;
    logic                 st_we;
    logic [xlen-1:0]      st_addr;
    logic [xlen-1:0]      st_data;

    logic active; // ir is a real instruction this cycle
    logic is_lui, is_addi, is_ld, is_sd, is_csrrw, is_mret;
    logic ld_go;  // Read strobe goes out this cycle
    logic ld_hold;
    logic wb_en;
    logic [xlen-1:0] wb_data;

    assign opcode  = ir[6:0];
    assign funct3  = ir[14:12];
    assign rd      = ir[11:7];
    assign rs1     = ir[19:15];
    assign rs2     = ir[24:20];
    assign imm_i   = {{(xlen-12){ir[31]}}, ir[31:20]};
    assign imm_s   = {{(xlen-12){ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_u   = {{(xlen-32){ir[31]}}, ir[31:12], 12'b0}; // Sign extended to 64 bits
    assign rs1_val = regs[rs1];
    assign rs2_val = regs[rs2];
    assign load_ea = rs1_val + imm_i;

    // The word in ir during the load steps is the one behind the LD, refetched later
    assign active   = ~bubble & ~load_step & ~load_wait;
    assign is_lui   = active & (opcode == op_lui);
    assign is_addi  = active & (opcode == op_op_imm) & (funct3 == funct3_addi);
    assign is_ld    = active & (opcode == op_load) & (funct3 == funct3_ld);
    assign is_sd    = active & (opcode == op_store) & (funct3 == funct3_sd);
    assign is_csrrw = active & (opcode == op_system) & (funct3 == funct3_csrrw);
    assign is_mret  = active & (ir == mret_word);

    assign ld_hold = is_ld & st_we;              // Bus busy with the previous SD write
    assign ld_go   = (is_ld & ~st_we) | load_wait;

    assign wb_en   = is_lui | is_addi | is_csrrw;
    assign wb_data = is_lui  ? imm_u :
                     is_addi ? rs1_val + imm_i :
                     trap_ctl.csr_rdata;         // CSRRW returns the old CSR value

    always_comb begin
        exec_ctl.stall     = is_ld | load_wait;  // Never high in the load_step cycle
        exec_ctl.mret      = is_mret;
        exec_ctl.csr_we    = is_csrrw;
        exec_ctl.csr_addr  = ir[31:20];
        exec_ctl.csr_wdata = rs1_val;
    end

    always_comb begin
        if (load_wait) begin
            bus.address = load_addr;
        end else if (ld_go) begin
            bus.address = load_ea;               // Read address straight from the adder
        end else begin
            bus.address = st_addr;
        end
        bus.write_data   = st_data;
        bus.write_enable = st_we;
        bus.read_enable  = ld_go;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
            load_step <= 1'b0;
            load_wait <= 1'b0;
            st_we     <= 1'b0;
        end else begin
            load_step <= ld_go;                  // Data arrives next cycle
            load_wait <= ld_hold;
            st_we     <= is_sd & ~trap_ctl.take; // One cycle strobe after SD
            if (!trap_ctl.take) begin
                if (load_step && load_rd != '0) begin
                    regs[load_rd] <= bus_read_data;
                end else if (wb_en && rd != '0) begin
                    regs[rd] <= wb_data;
                end
            end
        end
    end

    // Load and store payload
    always_ff @(posedge clk) begin
        if (is_ld) begin
            load_rd   <= rd;                     // ir moves on before the data returns
            load_addr <= load_ea;
        end
        if (is_sd) begin
            st_addr <= rs1_val + imm_s;
            st_data <= rs2_val;
        end
    end

endmodule

`default_nettype wire

//--- src/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage
    import rv_isa_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  wire [ilen-1:0]  instruction, // Word at the current pc
    input  wire             bubble,
    output logic [ilen-1:0] ir,
    output logic            heartbeat
);

    logic [ilen-1:0] ir_q; // Word fetched in the previous cycle

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir_q      <= nop_word; // Execute starts on a harmless NOP
            heartbeat <= 1'b0;
        end else begin
            ir_q      <= instruction;
            heartbeat <= ~heartbeat; // Liveness toggle
        end
    end

    // During a bubble ir_q holds the word fetched in the redirect cycle,
    // execute sees a NOP in its place while the target word is being fetched
    assign ir = bubble ? nop_word : ir_q;

endmodule

`default_nettype wire

//--- src/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

    localparam int bus_w = 64; // Address and data width of the data bus

    // Memory map
    localparam logic [bus_w-1:0] ram_base = 64'h0000_0000_0000_1000; // Reset pc
    localparam logic [bus_w-1:0] key_base = 64'h0000_0000_2000_0000; // Key input device
    localparam logic [bus_w-1:0] art_base = 64'h0000_0000_3000_0000; // Character output device

    // Data bus request
    // Strobes last one cycle, read data returns on the following cycle
    typedef struct packed {
        logic [bus_w-1:0] address;
        logic [bus_w-1:0] write_data;
        logic             write_enable;
        logic             read_enable;
    } bus_req_t;

endpackage

`default_nettype wire

//--- src/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int xlen       = 64;                // Register and pc width
    localparam int ilen       = 32;                // Instruction word
    localparam int reg_count  = 32;                // Architectural integer registers
    localparam int reg_idx_w  = $clog2(reg_count); // Register index, 5 bits
    localparam int opcode_w   = 7;
    localparam int funct3_w   = 3;
    localparam int csr_addr_w = 12;

    // Major opcodes of the supported subset
    localparam logic [opcode_w-1:0] op_lui    = 7'b0110111;
    localparam logic [opcode_w-1:0] op_op_imm = 7'b0010011;
    localparam logic [opcode_w-1:0] op_load   = 7'b0000011;
    localparam logic [opcode_w-1:0] op_store  = 7'b0100011;
    localparam logic [opcode_w-1:0] op_system = 7'b1110011;

    localparam logic [funct3_w-1:0] funct3_addi  = 3'b000;
    localparam logic [funct3_w-1:0] funct3_ld    = 3'b011; // Doubleword
    localparam logic [funct3_w-1:0] funct3_sd    = 3'b011;
    localparam logic [funct3_w-1:0] funct3_csrrw = 3'b001;

    localparam logic [ilen-1:0] mret_word = 32'h3020_0073; // Whole word compare
    localparam logic [ilen-1:0] nop_word  = 32'h0000_0013; // addi x0, x0, 0

    // Machine mode CSRs
    localparam logic [csr_addr_w-1:0] csr_mstatus = 12'h300;
    localparam logic [csr_addr_w-1:0] csr_mie     = 12'h304;
    localparam logic [csr_addr_w-1:0] csr_mtvec   = 12'h305;
    localparam logic [csr_addr_w-1:0] csr_mepc    = 12'h341;
    localparam logic [csr_addr_w-1:0] csr_mcause  = 12'h342;

    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    localparam int mie_meie_bit     = 11; // Machine external interrupt enable

    localparam logic [xlen-1:0] mcause_ext_irq = {1'b1, 63'd11}; // Interrupt flag, code 11

    // Execute results seen by the pc sequencer and the trap controller
    typedef struct packed {
        logic                  stall;     // Hold pc, load in progress
        logic                  mret;
        logic                  csr_we;
        logic [csr_addr_w-1:0] csr_addr;
        logic [xlen-1:0]       csr_wdata;
    } exec_ctl_t;

    typedef struct packed {
        logic            take;      // Interrupt taken this cycle
        logic [xlen-1:0] target;    // mtvec on a take, mepc on an mret
        logic [xlen-1:0] csr_rdata;
    } trap_ctl_t;

endpackage

`default_nettype wire
